// File: logic/dmb_cfg_pkg.sv
package dmb_cfg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Front-end boards and trigger vectors
	//////////////////////////////////////////////////////////////////////

	// Five CFEBs on the motherboard
	localparam int NUM_CFEB = 5;

	// Bit 0 is the global LCT, bits 5..1 go one per board
	localparam int LCT_W = NUM_CFEB + 1;

	//////////////////////////////////////////////////////////////////////
	// Latency timers
	//////////////////////////////////////////////////////////////////////

	localparam int TIMER_W    = 8;
	localparam int NUM_TIMERS = 4;

	// DAV monitor bits: CFEB, TMB, ALCT
	localparam int DAV_MON_W = 3;

	// Power-up sequencing lengths in clkcms cycles
	localparam int FPGA_RST_CYCLES = 16;
	localparam int POH_CYCLES_DEF  = 65535;

endpackage

// File: logic/dmb_trig_pkg.sv
package dmb_trig_pkg;

	import dmb_cfg_pkg::*;

	// One bit per front-end board
	typedef logic [NUM_CFEB-1:0] cfeb_vec_t;

	// Single latency measurement
	typedef logic [TIMER_W-1:0] timer_val_t;

	// All timers side by side, LCT in the low byte then CFEB, TMB, ALCT
	typedef logic [NUM_TIMERS*TIMER_W-1:0] tm_count_t;

	// Power-up reset sequence
	typedef enum logic [1:0]
	{
		RST_WAIT_RDY,
		RST_LOCAL,
		RST_HOLDOFF,
		RST_RUN
	} rst_state_t;

endpackage

// File: logic/reset_sequencer.sv
`timescale 1ns/10ps

module reset_sequencer
	import dmb_cfg_pkg::*, dmb_trig_pkg::*;
#(
	parameter int POH_CYCLES = POH_CYCLES_DEF
)
(
	input  logic clkcms,
	input  logic rst,
	input  logic fpga_ready_i,
	output logic fpga_rst_o,
	output logic holdoff_o,
	output logic ctrl_ready_o
);

	// One down-counter covers both the local reset and the holdoff
	localparam int CNT_MAX = (POH_CYCLES > FPGA_RST_CYCLES) ? POH_CYCLES : FPGA_RST_CYCLES;
	localparam int CNT_W   = $clog2(CNT_MAX + 1);

	logic             rdy_s1;
	logic             rdy_s2;
	logic             rdy_d;
	logic             rdy_rise;
	rst_state_t       state;
	logic [CNT_W-1:0] cnt;

	//////////////////////////////////////////////////////////////////////
	// Ready synchronizer and edge detect
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			rdy_s1 <= 1'b0;
			rdy_s2 <= 1'b0;
			rdy_d  <= 1'b0;
		end
		else
		begin
			rdy_s1 <= fpga_ready_i;
			rdy_s2 <= rdy_s1;
			rdy_d  <= rdy_s2;
		end
	end

	assign rdy_rise = rdy_s2 & ~rdy_d;

	//////////////////////////////////////////////////////////////////////
	// Sequence FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			state <= RST_WAIT_RDY;
			cnt   <= '0;
		end
		else if (!rdy_s2)
		begin
			// Losing ready restarts everything
			state <= RST_WAIT_RDY;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				RST_WAIT_RDY:
					if (rdy_rise)
					begin
						state <= RST_LOCAL;
						cnt   <= CNT_W'(FPGA_RST_CYCLES - 1);
					end
				RST_LOCAL:
					if (cnt == '0)
					begin
						state <= RST_HOLDOFF;
						cnt   <= CNT_W'(POH_CYCLES - 1);
					end
					else
						cnt <= cnt - 1'b1;
				RST_HOLDOFF:
					if (cnt == '0)
						state <= RST_RUN;
					else
						cnt <= cnt - 1'b1;
				default:
					state <= RST_RUN;
			endcase
		end
	end

	assign fpga_rst_o   = (state == RST_LOCAL);
	assign holdoff_o    = (state == RST_HOLDOFF);
	assign ctrl_ready_o = (state == RST_HOLDOFF) || (state == RST_RUN);

endmodule

// File: logic/trg_timer.sv
`timescale 1ns/10ps

module trg_timer
	import dmb_trig_pkg::*;
(
	input  logic       clkcms,
	input  logic       rst,
	input  logic       holdoff_i,
	input  logic       clr_i,
	input  logic       start_i,
	input  logic       stop_i,
	output timer_val_t time_o
);

	logic       armed;
	logic       running;
	timer_val_t cnt;

	//////////////////////////////////////////////////////////////////////
	// One-shot latency measurement
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			armed   <= 1'b1;
			running <= 1'b0;
			cnt     <= '0;
		end
		else if (clr_i)
		begin
			// Rearm for the next measurement
			armed   <= 1'b1;
			running <= 1'b0;
			cnt     <= '0;
		end
		else if (armed && !holdoff_i && start_i)
		begin
			armed   <= 1'b0;
			running <= 1'b1;
			cnt     <= '0;
		end
		else if (running)
		begin
			// Hold at full scale
			if (cnt != '1)
				cnt <= cnt + 1'b1;
			if (stop_i)
				running <= 1'b0;
		end
	end

	assign time_o = cnt;

endmodule

// File: logic/trig_encoder.sv
`timescale 1ns/10ps

module trig_encoder
	import dmb_cfg_pkg::*, dmb_trig_pkg::*;
(
	input  logic      clkcms,
	input  logic      rst,
	input  logic      resync_i,
	input  logic      dcfeb_in_use_i,
	input  logic      cable_dly_i,
	input  logic      l1a_cfeb_i,
	input  cfeb_vec_t lct_i,
	input  cfeb_vec_t l1a_match_i,
	output cfeb_vec_t enc_b0_o,
	output cfeb_vec_t enc_b1_o,
	output cfeb_vec_t enc_b2_o
);

	cfeb_vec_t enc_b0;
	cfeb_vec_t enc_b1;
	cfeb_vec_t enc_b2;
	cfeb_vec_t enc_b0_d;
	cfeb_vec_t enc_b1_d;
	cfeb_vec_t enc_b2_d;

	//////////////////////////////////////////////////////////////////////
	// Encoding
	//////////////////////////////////////////////////////////////////////

	// DCFEBs take L1A-match on bit 0, older boards take the LCT
	assign enc_b0 = dcfeb_in_use_i ? l1a_match_i : lct_i;
	assign enc_b1 = {NUM_CFEB{l1a_cfeb_i}};
	assign enc_b2 = {NUM_CFEB{resync_i}};

	// Extra cycle for long cables
	always_ff @(posedge clkcms)
	begin
		enc_b0_d <= enc_b0;
		enc_b1_d <= enc_b1;
		enc_b2_d <= enc_b2;
	end

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			enc_b0_o <= '0;
			enc_b1_o <= '0;
			enc_b2_o <= '0;
		end
		else
		begin
			enc_b0_o <= cable_dly_i ? enc_b0_d : enc_b0;
			enc_b1_o <= cable_dly_i ? enc_b1_d : enc_b1;
			enc_b2_o <= cable_dly_i ? enc_b2_d : enc_b2;
		end
	end

endmodule

// File: logic/dmb_trig_top.sv
`timescale 1ns/10ps

module dmb_trig_top
	import dmb_cfg_pkg::*, dmb_trig_pkg::*;
#(
	parameter int POH_CYCLES = POH_CYCLES_DEF
)
(
	input  logic                 clkcms,
	input  logic                 rst,
	input  logic                 fpga_ready_i,
	input  logic                 resync_i,
	input  logic                 dcfeb_in_use_i,
	input  logic                 cable_dly_i,
	input  logic [LCT_W-1:0]     lct_i,
	input  logic [LCT_W-1:0]     l1a_match_i,
	input  logic                 l1a_cfeb_i,
	input  logic                 gfpush_i,
	input  logic                 dpush_i,
	input  logic [DAV_MON_W-1:0] dav_mon_i,
	input  logic                 timer_clr_i,
	output cfeb_vec_t            trg_enc_b0_o,
	output cfeb_vec_t            trg_enc_b1_o,
	output cfeb_vec_t            trg_enc_b2_o,
	output logic                 fpga_rst_b_o,
	output logic                 holdoff_o,
	output logic                 ctrl_ready_o,
	output tm_count_t            tm_count_o
);

	logic                  fpga_rst;
	logic                  holdoff;
	logic                  int_rst;
	logic                  resync;
	logic [NUM_TIMERS-1:0] tmr_start;
	logic [NUM_TIMERS-1:0] tmr_stop;

	//////////////////////////////////////////////////////////////////////
	// Resets and holdoff
	//////////////////////////////////////////////////////////////////////

	reset_sequencer #(
		.POH_CYCLES(POH_CYCLES)
	) u_rst_seq (
		.clkcms      (clkcms),
		.rst         (rst),
		.fpga_ready_i(fpga_ready_i),
		.fpga_rst_o  (fpga_rst),
		.holdoff_o   (holdoff),
		.ctrl_ready_o(ctrl_ready_o)
	);

	assign int_rst      = rst | fpga_rst;
	assign resync       = resync_i | fpga_rst;
	assign fpga_rst_b_o = ~fpga_rst;
	assign holdoff_o    = holdoff;

	//////////////////////////////////////////////////////////////////////
	// Trigger encoding to the CFEBs
	//////////////////////////////////////////////////////////////////////

	// Global bit 0 of LCT and L1A-match stays on the board
	trig_encoder u_trig_enc (
		.clkcms        (clkcms),
		.rst           (int_rst),
		.resync_i      (resync),
		.dcfeb_in_use_i(dcfeb_in_use_i),
		.cable_dly_i   (cable_dly_i),
		.l1a_cfeb_i    (l1a_cfeb_i),
		.lct_i         (lct_i[LCT_W-1:1]),
		.l1a_match_i   (l1a_match_i[LCT_W-1:1]),
		.enc_b0_o      (trg_enc_b0_o),
		.enc_b1_o      (trg_enc_b1_o),
		.enc_b2_o      (trg_enc_b2_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Latency timers: LCT, CFEB DAV, TMB DAV, ALCT DAV
	//////////////////////////////////////////////////////////////////////

	assign tmr_start = {dav_mon_i, lct_i[0]};
	assign tmr_stop  = {{DAV_MON_W{dpush_i}}, gfpush_i};

	for (genvar i = 0; i < NUM_TIMERS; i++)
	begin : g_tmr
		trg_timer u_tmr (
			.clkcms   (clkcms),
			.rst      (int_rst),
			.holdoff_i(holdoff),
			.clr_i    (timer_clr_i),
			.start_i  (tmr_start[i]),
			.stop_i   (tmr_stop[i]),
			.time_o   (tm_count_o[i*TIMER_W +: TIMER_W])
		);
	end

endmodule

// File: dv/tb_dmb_trig_top.sv
`timescale 1ns/10ps

module tb_dmb_trig_top
	import dmb_cfg_pkg::*, dmb_trig_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int POH        = 64;
	localparam int MAX_N      = 40;
	localparam int ENC_CYCLES = 200;
	localparam int SEQ_CYCLES = 3 + FPGA_RST_CYCLES + POH + 8;
	// Cycle budget of all tests plus margin
	localparam int WD_CYCLES  = 16 + 3 * SEQ_CYCLES + 2 * (ENC_CYCLES + 8)
		+ NUM_TIMERS * (2 * MAX_N + 16) + 200;

	logic                   clkcms;
	logic                   rst;
	logic                   fpga_ready_i, resync_i, dcfeb_in_use_i, cable_dly_i;
	logic [LCT_W-1:0]       lct_i, l1a_match_i;
	logic                   l1a_cfeb_i, gfpush_i, dpush_i, timer_clr_i;
	logic [DAV_MON_W-1:0]   dav_mon_i;
	cfeb_vec_t              trg_enc_b0_o, trg_enc_b1_o, trg_enc_b2_o;
	logic                   fpga_rst_b_o, holdoff_o, ctrl_ready_o;
	tm_count_t              tm_count_o;
	logic [3*NUM_CFEB-1:0]  exp_enc, enc_out;
	int                     lo_len, hold_len, err_cnt, tests_run, tests_failed;

	dmb_trig_top #(.POH_CYCLES(POH)) DUT (.*);

	always #(CLK_PERIOD / 2) clkcms = ~clkcms;

	//////////////////////////////////////////////////////////////////////
	// Reference rules and phase length monitors
	//////////////////////////////////////////////////////////////////////

	assign exp_enc = {{NUM_CFEB{resync_i}}, {NUM_CFEB{l1a_cfeb_i}},
		dcfeb_in_use_i ? l1a_match_i[LCT_W-1:1] : lct_i[LCT_W-1:1]};
	assign enc_out = {trg_enc_b2_o, trg_enc_b1_o, trg_enc_b0_o};

	always_ff @(posedge clkcms or posedge rst)
	begin
		if (rst)
		begin
			lo_len   <= 0;
			hold_len <= 0;
		end
		else
		begin
			lo_len   <= fpga_rst_b_o ? 0 : lo_len + 1;
			hold_len <= holdoff_o ? hold_len + 1 : 0;
		end
	end

	task automatic report_fail(input string msg);
		err_cnt++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	ready_rise_starts_rst: assert property (@(posedge clkcms) disable iff (rst)
		$past(fpga_ready_i, 3) && !$past(fpga_ready_i, 4) |-> !fpga_rst_b_o)
		else report_fail("local reset did not start after fpga_ready rise");
	rst_length: assert property (@(posedge clkcms) disable iff (rst)
		$rose(fpga_rst_b_o) |-> lo_len == FPGA_RST_CYCLES && $rose(ctrl_ready_o) && holdoff_o)
		else report_fail($sformatf("local reset lasted %0d cycles or ready did not follow",
			lo_len));
	holdoff_length: assert property (@(posedge clkcms) disable iff (rst)
		$fell(holdoff_o) && ctrl_ready_o |-> hold_len == POH)
		else report_fail($sformatf("holdoff lasted %0d cycles", hold_len));
	ready_loss: assert property (@(posedge clkcms) disable iff (rst)
		!$past(fpga_ready_i, 3) |-> !ctrl_ready_o)
		else report_fail("ctrl_ready_o still high after fpga_ready loss");
	// Checks skip the cycles touched by the local reset
	enc_direct: assert property (@(posedge clkcms) disable iff (rst)
		!$past(cable_dly_i) && fpga_rst_b_o && $past(fpga_rst_b_o)
		|-> enc_out == $past(exp_enc))
		else report_fail($sformatf("encoder out %h without cable delay", enc_out));
	enc_delayed: assert property (@(posedge clkcms) disable iff (rst)
		$past(cable_dly_i) && fpga_rst_b_o && $past(fpga_rst_b_o) && $past(fpga_rst_b_o, 2)
		|-> enc_out == $past(exp_enc, 2))
		else report_fail($sformatf("encoder out %h with cable delay", enc_out));

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge clkcms);
		#1;
	endtask

	task automatic wait_phase(input logic want_holdoff);
		int cyc;
		cyc = 0;
		while (!(ctrl_ready_o && holdoff_o == want_holdoff) && cyc < SEQ_CYCLES)
		begin
			step();
			cyc++;
		end
		if (!(ctrl_ready_o && holdoff_o == want_holdoff))
		begin
			err_cnt++;
			$display("Reset sequence did not reach the expected phase in %0d cycles", cyc);
		end
	endtask

	task automatic restart_ready(input logic want_holdoff);
		fpga_ready_i = 1'b0;
		repeat (4) step();
		fpga_ready_i = 1'b1;
		wait_phase(want_holdoff);
	endtask

	task automatic pulse_clear();
		timer_clr_i = 1'b1;
		step();
		timer_clr_i = 1'b0;
	endtask

	task automatic pulse_start_stop(input logic [NUM_TIMERS-1:0] starts, input int n);
		{dav_mon_i, lct_i[0]} = starts;
		step();
		{dav_mon_i, lct_i[0]} = '0;
		repeat (n - 1) step();
		{dpush_i, gfpush_i} = {|starts[NUM_TIMERS-1:1], starts[0]};
		step();
		{dpush_i, gfpush_i} = 2'b00;
	endtask

	task automatic measure_timer(input int idx, input int n);
		pulse_clear();
		pulse_start_stop(NUM_TIMERS'(1) << idx, n);
		assert (tm_count_o == tm_count_t'(n) << (idx * TIMER_W))
		else report_fail($sformatf("timer %0d: tm_count %h, expected %0d", idx, tm_count_o, n));
		// Second start before a clear is ignored
		pulse_start_stop(NUM_TIMERS'(1) << idx, 3);
		assert (timer_val_t'(tm_count_o >> (idx * TIMER_W)) == TIMER_W'(n))
		else report_fail($sformatf("timer %0d changed after second start", idx));
	endtask

	task automatic run_encoding(input logic dly);
		cable_dly_i = dly;
		repeat (ENC_CYCLES)
		begin
			lct_i          = LCT_W'($urandom());
			l1a_match_i    = LCT_W'($urandom());
			l1a_cfeb_i     = 1'($urandom());
			dcfeb_in_use_i = 1'($urandom());
			resync_i       = 1'($urandom());
			step();
		end
		{lct_i, l1a_match_i, l1a_cfeb_i, dcfeb_in_use_i, resync_i} = '0;
		repeat (3) step();
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (err_cnt != errs_before)
			tests_failed++;
		$display("Test %0d %s: %s", tests_run, name,
			(err_cnt == errs_before) ? "passed" : "failed");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int errs;
		void'($urandom(32'h061c_4e92));
		{clkcms, fpga_ready_i, resync_i, dcfeb_in_use_i, cable_dly_i} = '0;
		{lct_i, l1a_match_i, l1a_cfeb_i, gfpush_i, dpush_i, dav_mon_i, timer_clr_i} = '0;
		{err_cnt, tests_run, tests_failed} = '0;
		rst = 1'b1;
		repeat (16) @(posedge clkcms);
		#1 rst = 1'b0;
		step();
		errs = err_cnt;
		assert ({ctrl_ready_o, holdoff_o, fpga_rst_b_o} == 3'b001 && enc_out == '0
			&& tm_count_o == '0)
		else report_fail("outputs not inactive after reset");
		end_test("reset state", errs);
		errs = err_cnt;
		restart_ready(1'b0);
		end_test("reset sequence", errs);
		errs = err_cnt;
		restart_ready(1'b0);
		end_test("ready loss", errs);
		errs = err_cnt;
		run_encoding(1'b0);
		end_test("encoding direct", errs);
		errs = err_cnt;
		run_encoding(1'b1);
		end_test("encoding with cable delay", errs);
		errs = err_cnt;
		for (int t = 0; t < NUM_TIMERS; t++)
			measure_timer(t, $urandom_range(MAX_N, 1));
		end_test("timer latency", errs);
		errs = err_cnt;
		restart_ready(1'b1);
		pulse_clear();
		pulse_start_stop('1, 5);
		assert (holdoff_o && tm_count_o == '0)
		else report_fail($sformatf("timers %h during holdoff", tm_count_o));
		wait_phase(1'b0);
		end_test("holdoff blocks timers", errs);
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("Run timed out after %0d clock cycles", WD_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: project.f
logic/dmb_cfg_pkg.sv
logic/dmb_trig_pkg.sv
logic/reset_sequencer.sv
logic/trg_timer.sv
logic/trig_encoder.sv
logic/dmb_trig_top.sv
dv/tb_dmb_trig_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dmb_trig_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
